/* hdl/cpu8_pkg.sv */
package cpu8_pkg;

  // Microcode address is the opcode above the micro-op step
  localparam int step_w       = 5;
  localparam int opcode_w     = 6;
  localparam int ucode_addr_w = opcode_w + step_w;
  localparam int ucode_word_w = 32;

  // Control word field positions
  localparam int reg_src_lsb   = 0;
  localparam int reg_src_msb   = 1;
  localparam int reg_sel_lsb   = 2;
  localparam int reg_sel_msb   = 3;
  localparam int alu_plane_lsb = 4;
  localparam int alu_plane_msb = 7;
  localparam int out_plane_lsb = 8;
  localparam int out_plane_msb = 10;
  localparam int in_plane_lsb  = 11;
  localparam int in_plane_msb  = 13;
  localparam int restart_bit   = 14;
  // Bits above the restart flag are spare
  localparam int ctrl_w        = restart_bit + 1;

  // Layout inside the ALU plane
  localparam int alu_plane_w   = alu_plane_msb - alu_plane_lsb + 1;
  localparam int mlu_op_lsb    = 0;
  localparam int mlu_op_msb    = 2;
  localparam int mlu_carry_bit = 3;
  localparam int shift_op_lsb  = 0;
  localparam int shift_op_msb  = 1;

  // Destination written from the bus, codes 6 and 7 write nothing
  typedef enum logic [2:0] {
    in_none, in_reg, in_tmp0, in_tmp1, in_opcode, in_out_port
  } in_plane_e;

  // Source driven onto the bus, code 7 leaves the bus at zero
  typedef enum logic [2:0] {
    out_none, out_reg, out_tmp0, out_tmp1, out_mlu, out_shifter, out_in_port
  } out_plane_e;

  // Register index source, value 3 is illegal
  typedef enum logic [1:0] {sel_op_reg0, sel_op_reg1, sel_ctrl} reg_sel_e;

  typedef enum logic [2:0] {
    mlu_and, mlu_or, mlu_xor, mlu_add, mlu_sub, mlu_not_a, mlu_pass_a, mlu_inc_a
  } mlu_op_e;

  // Left arithmetic makes no sense, so code 3 is illegal
  typedef enum logic [1:0] {shift_sll, shift_srl, shift_sra} shift_op_e;

endpackage

/* hdl/microcode_store.sv */
`timescale 1ns/10ps

module microcode_store (
  input  logic                              clk,
  input  logic [cpu8_pkg::ucode_addr_w-1:0] ucode_addr,
  output logic [cpu8_pkg::ucode_word_w-1:0] ucode_word,
  input  logic                              boot_we,
  input  logic [cpu8_pkg::ucode_addr_w+1:0] boot_addr,
  input  logic [7:0]                        boot_data
);
  import cpu8_pkg::*;

  localparam int depth = 1 << ucode_addr_w;

  logic [ucode_word_w-1:0] mem [depth];
  logic [ucode_addr_w-1:0] boot_word;
  logic [1:0]              boot_lane;

  // Store powers up blank until the loader fills it
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // Low two address bits pick the byte lane, lane 3 is the top byte
  assign boot_word = boot_addr[ucode_addr_w+1:2];
  assign boot_lane = boot_addr[1:0];

  // Bootstrap writes, one byte per strobe
  always_ff @(posedge clk) begin
    if (boot_we) begin
      mem[boot_word][boot_lane*8 +: 8] <= boot_data;
    end
  end

  // Asynchronous read so decode can register the next word in the same cycle
  assign ucode_word = mem[ucode_addr];

endmodule

/* hdl/control_logic.sv */
`timescale 1ns/10ps

module control_logic #(
  parameter int data_w   = 8,
  parameter int num_regs = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              booted,
  input  logic [data_w-1:0]                 bus,
  input  logic [cpu8_pkg::ucode_word_w-1:0] ucode_word,
  output logic [cpu8_pkg::ucode_addr_w-1:0] ucode_addr,
  output logic [cpu8_pkg::opcode_w-1:0]     opcode,
  output logic [$clog2(num_regs)-1:0]       reg_index,
  output logic [cpu8_pkg::alu_plane_w-1:0]  alu_plane,
  output logic                              reg_we,
  output logic                              tmp0_we,
  output logic                              tmp1_we,
  output logic                              out_port_we,
  output logic                              src_reg,
  output logic                              src_tmp0,
  output logic                              src_tmp1,
  output logic                              src_mlu,
  output logic                              src_shifter,
  output logic                              src_in_port
);
  import cpu8_pkg::*;

  localparam int idx_w = $clog2(num_regs);

  logic [ctrl_w-1:0]   ctrl_q;
  logic [step_w-1:0]   step_q;
  logic [step_w-1:0]   step_next;
  logic [opcode_w-1:0] opcode_q;
  logic [opcode_w-1:0] opcode_next;
  logic [1:0]          reg_src;
  logic [1:0]          sel_bits;
  logic                restart;
  logic                opcode_we;
  reg_sel_e            reg_sel;
  in_plane_e           in_plane;
  out_plane_e          out_plane;

  // Fields of the registered control word
  assign reg_src   = ctrl_q[reg_src_msb:reg_src_lsb];
  assign reg_sel   = reg_sel_e'(ctrl_q[reg_sel_msb:reg_sel_lsb]);
  assign alu_plane = ctrl_q[alu_plane_msb:alu_plane_lsb];
  assign out_plane = out_plane_e'(ctrl_q[out_plane_msb:out_plane_lsb]);
  assign in_plane  = in_plane_e'(ctrl_q[in_plane_msb:in_plane_lsb]);
  assign restart   = ctrl_q[restart_bit];

  // Next step restarts at 0 or counts on, wrapping at 32
  assign step_next   = restart ? '0 : step_q + step_w'(1);
  // Opcode write together with restart gives a dispatch
  assign opcode_next = opcode_we ? bus[opcode_w-1:0] : opcode_q;
  assign ucode_addr  = {opcode_next, step_next};
  assign opcode      = opcode_q;

  // Step 31 with a no-op word means boot lands on step 0 of opcode 0
  always_ff @(posedge clk) begin
    if (rst || !booted) begin
      ctrl_q   <= '0;
      step_q   <= '1;
      opcode_q <= '0;
    end else begin
      ctrl_q   <= ucode_word[ctrl_w-1:0];
      step_q   <= step_next;
      opcode_q <= opcode_next;
    end
  end

  // In plane decoder
  assign reg_we      = (in_plane == in_reg);
  assign tmp0_we     = (in_plane == in_tmp0);
  assign tmp1_we     = (in_plane == in_tmp1);
  assign opcode_we   = (in_plane == in_opcode);
  assign out_port_we = (in_plane == in_out_port);

  // Out plane decoder, one-hot
  assign src_reg     = (out_plane == out_reg);
  assign src_tmp0    = (out_plane == out_tmp0);
  assign src_tmp1    = (out_plane == out_tmp1);
  assign src_mlu     = (out_plane == out_mlu);
  assign src_shifter = (out_plane == out_shifter);
  assign src_in_port = (out_plane == out_in_port);

  // Register index from an opcode field or the word itself
  always_comb begin
    case (reg_sel)
      sel_op_reg0: sel_bits = opcode_q[1:0];
      sel_op_reg1: sel_bits = opcode_q[3:2];
      default:     sel_bits = reg_src;
    endcase
  end

  assign reg_index = idx_w'(sel_bits % num_regs);

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/10ps

module execute_unit #(
  parameter int data_w = 8
) (
  input  logic [data_w-1:0]                tmp0,
  input  logic [data_w-1:0]                tmp1,
  input  logic [cpu8_pkg::alu_plane_w-1:0] alu_plane,
  output logic [data_w-1:0]                mlu_result,
  output logic [data_w-1:0]                shift_result
);
  import cpu8_pkg::*;

  mlu_op_e           mlu_op;
  shift_op_e         shift_op;
  logic [data_w-1:0] carry_in;

  // MLU takes the full plane, shifter only the low two bits
  assign mlu_op   = mlu_op_e'(alu_plane[mlu_op_msb:mlu_op_lsb]);
  assign shift_op = shift_op_e'(alu_plane[shift_op_msb:shift_op_lsb]);
  // Carry-in widened to the operand width
  assign carry_in = {{(data_w-1){1'b0}}, alu_plane[mlu_carry_bit]};

  // MLU with tmp0 as a and tmp1 as b
  always_comb begin
    case (mlu_op)
      mlu_and:    mlu_result = tmp0 & tmp1;
      mlu_or:     mlu_result = tmp0 | tmp1;
      mlu_xor:    mlu_result = tmp0 ^ tmp1;
      // Sums wrap at the data width
      mlu_add:    mlu_result = tmp0 + tmp1 + carry_in;
      mlu_sub:    mlu_result = tmp0 - tmp1 - carry_in;
      mlu_not_a:  mlu_result = ~tmp0;
      mlu_pass_a: mlu_result = tmp0;
      mlu_inc_a:  mlu_result = tmp0 + data_w'(1);
      default:    mlu_result = tmp0;
    endcase
  end

  // One-bit shifter on tmp0
  always_comb begin
    case (shift_op)
      shift_sll: shift_result = {tmp0[data_w-2:0], 1'b0};
      shift_srl: shift_result = {1'b0, tmp0[data_w-1:1]};
      // Sign bit copied down
      shift_sra: shift_result = {tmp0[data_w-1], tmp0[data_w-1:1]};
      // Illegal code passes a through
      default:   shift_result = tmp0;
    endcase
  end

endmodule

/* hdl/register_planes.sv */
`timescale 1ns/10ps

module register_planes #(
  parameter int data_w   = 8,
  parameter int num_regs = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [$clog2(num_regs)-1:0] reg_index,
  input  logic                        reg_we,
  input  logic                        tmp0_we,
  input  logic                        tmp1_we,
  input  logic                        out_port_we,
  input  logic                        src_reg,
  input  logic                        src_tmp0,
  input  logic                        src_tmp1,
  input  logic                        src_mlu,
  input  logic                        src_shifter,
  input  logic                        src_in_port,
  input  logic [data_w-1:0]           mlu_result,
  input  logic [data_w-1:0]           shift_result,
  input  logic [data_w-1:0]           in_port,
  output logic [data_w-1:0]           bus,
  output logic [data_w-1:0]           tmp0,
  output logic [data_w-1:0]           tmp1,
  output logic [data_w-1:0]           out_port
);

  logic [data_w-1:0] regs [num_regs];
  logic [data_w-1:0] reg_rd;

  assign reg_rd = regs[reg_index];

  // Bus is an AND-OR of one-hot selects, zero when nothing drives it
  assign bus = ({data_w{src_reg}}     & reg_rd)
             | ({data_w{src_tmp0}}    & tmp0)
             | ({data_w{src_tmp1}}    & tmp1)
             | ({data_w{src_mlu}}     & mlu_result)
             | ({data_w{src_shifter}} & shift_result)
             | ({data_w{src_in_port}} & in_port);

  // General registers
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_we) begin
      regs[reg_index] <= bus;
    end
  end

  // Temporaries feeding the execute block
  always_ff @(posedge clk) begin
    if (rst) begin
      tmp0 <= '0;
      tmp1 <= '0;
    end else begin
      if (tmp0_we) begin
        tmp0 <= bus;
      end
      if (tmp1_we) begin
        tmp1 <= bus;
      end
    end
  end

  // Output port updates at the edge ending the writing micro-op
  always_ff @(posedge clk) begin
    if (rst) begin
      out_port <= '0;
    end else if (out_port_we) begin
      out_port <= bus;
    end
  end

endmodule

/* hdl/cpu8_core.sv */
`timescale 1ns/10ps

module cpu8_core #(
  parameter int data_w   = 8,
  parameter int num_regs = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              booted,
  input  logic                              boot_we,
  input  logic [cpu8_pkg::ucode_addr_w+1:0] boot_addr,
  input  logic [7:0]                        boot_data,
  input  logic [data_w-1:0]                 in_port,
  output logic [data_w-1:0]                 out_port,
  output logic [cpu8_pkg::opcode_w-1:0]     opcode
);
  import cpu8_pkg::*;

  logic [ucode_addr_w-1:0]     ucode_addr;
  logic [ucode_word_w-1:0]     ucode_word;
  logic [$clog2(num_regs)-1:0] reg_index;
  logic [alu_plane_w-1:0]      alu_plane;
  logic [data_w-1:0]           bus;
  logic [data_w-1:0]           tmp0;
  logic [data_w-1:0]           tmp1;
  logic [data_w-1:0]           mlu_result;
  logic [data_w-1:0]           shift_result;
  logic reg_we;
  logic tmp0_we;
  logic tmp1_we;
  logic out_port_we;
  logic src_reg;
  logic src_tmp0;
  logic src_tmp1;
  logic src_mlu;
  logic src_shifter;
  logic src_in_port;

  // Microcode memory, filled by the loader during boot
  microcode_store i_microcode_store (
    .clk        (clk),
    .ucode_addr (ucode_addr),
    .ucode_word (ucode_word),
    .boot_we    (boot_we),
    .boot_addr  (boot_addr),
    .boot_data  (boot_data)
  );

  // Decode block, sequencing and plane decoders
  control_logic #(
    .data_w   (data_w),
    .num_regs (num_regs)
  ) i_control_logic (
    .clk         (clk),
    .rst         (rst),
    .booted      (booted),
    .bus         (bus),
    .ucode_word  (ucode_word),
    .ucode_addr  (ucode_addr),
    .opcode      (opcode),
    .reg_index   (reg_index),
    .alu_plane   (alu_plane),
    .reg_we      (reg_we),
    .tmp0_we     (tmp0_we),
    .tmp1_we     (tmp1_we),
    .out_port_we (out_port_we),
    .src_reg     (src_reg),
    .src_tmp0    (src_tmp0),
    .src_tmp1    (src_tmp1),
    .src_mlu     (src_mlu),
    .src_shifter (src_shifter),
    .src_in_port (src_in_port)
  );

  // MLU and shifter on the temporaries
  execute_unit #(
    .data_w (data_w)
  ) i_execute_unit (
    .tmp0         (tmp0),
    .tmp1         (tmp1),
    .alu_plane    (alu_plane),
    .mlu_result   (mlu_result),
    .shift_result (shift_result)
  );

  // Registers, ports and the internal bus
  register_planes #(
    .data_w   (data_w),
    .num_regs (num_regs)
  ) i_register_planes (
    .clk          (clk),
    .rst          (rst),
    .reg_index    (reg_index),
    .reg_we       (reg_we),
    .tmp0_we      (tmp0_we),
    .tmp1_we      (tmp1_we),
    .out_port_we  (out_port_we),
    .src_reg      (src_reg),
    .src_tmp0     (src_tmp0),
    .src_tmp1     (src_tmp1),
    .src_mlu      (src_mlu),
    .src_shifter  (src_shifter),
    .src_in_port  (src_in_port),
    .mlu_result   (mlu_result),
    .shift_result (shift_result),
    .in_port      (in_port),
    .bus          (bus),
    .tmp0         (tmp0),
    .tmp1         (tmp1),
    .out_port     (out_port)
  );

endmodule

/* sim/cpu8_assertions.sv */
`timescale 1ns/10ps

module cpu8_assertions (
  input logic       clk,
  input logic       rst,
  input logic       booted,
  input logic [1:0] reg_sel,
  input logic [3:0] alu_plane,
  input logic       reg_we,
  input logic       tmp0_we,
  input logic       tmp1_we,
  input logic       opcode_we,
  input logic       out_port_we,
  input logic       src_reg,
  input logic       src_tmp0,
  input logic       src_tmp1,
  input logic       src_shifter
);

  // Count of failed properties, read by the testbench
  int unsigned fail_count = 0;
  logic        any_we;

  assign any_we = reg_we | tmp0_we | tmp1_we | opcode_we | out_port_we;

  // Select code 3 names no register
  a_reg_sel: assert property (@(posedge clk) disable iff (rst)
    (reg_we || src_reg) |-> reg_sel != 2'd3)
    else begin
      fail_count++;
      $error("register select code 3 while a register is in use");
    end

  // A plane is never written from itself
  a_src_dst: assert property (@(posedge clk) disable iff (rst)
    !((reg_we && src_reg) || (tmp0_we && src_tmp0) || (tmp1_we && src_tmp1)))
    else begin
      fail_count++;
      $error("destination is also the active bus source");
    end

  // Shift code 3 is undefined
  a_shift_op: assert property (@(posedge clk) disable iff (rst)
    src_shifter |-> alu_plane[1:0] != 2'd3)
    else begin
      fail_count++;
      $error("shifter selected with illegal shift code");
    end

  // Held core writes nothing, control word clears at the edge
  a_held_idle: assert property (@(posedge clk)
    (rst || !booted) |=> !any_we)
    else begin
      fail_count++;
      $error("write enable active while held in reset or boot");
    end

endmodule

bind control_logic cpu8_assertions i_cpu8_assertions (
  .clk         (clk),
  .rst         (rst),
  .booted      (booted),
  .reg_sel     (reg_sel),
  .alu_plane   (alu_plane),
  .reg_we      (reg_we),
  .tmp0_we     (tmp0_we),
  .tmp1_we     (tmp1_we),
  .opcode_we   (opcode_we),
  .out_port_we (out_port_we),
  .src_reg     (src_reg),
  .src_tmp0    (src_tmp0),
  .src_tmp1    (src_tmp1),
  .src_shifter (src_shifter)
);

/* sim/cpu8_tb.sv */
`timescale 1ns/10ps

module cpu8_tb;
  import cpu8_pkg::*;

  localparam int clk_period = 40;
  localparam int n_words    = 106;
  localparam int n_rounds   = 4;
  // Reset cycles plus four byte writes per microcode word
  localparam int boot_cycles    = 8 + 4 * n_words + 4;
  // Loads, readback, MLU, shifter, restart and reset phases
  localparam int prog_cycles    = 16 + 32 + n_rounds * 43 + n_rounds * 18 + 20 + 30;
  localparam int timeout_cycles = 2 * (boot_cycles + prog_cycles);

  logic        clk;
  logic        rst;
  logic        booted;
  logic        boot_we;
  logic [12:0] boot_addr;
  logic [7:0]  boot_data;
  logic [7:0]  in_port;
  logic [7:0]  out_port;
  logic [5:0]  opcode;
  logic [31:0] done_w;
  logic [7:0]  a;
  logic [7:0]  b;

  cpu8_core #(
    .data_w   (8),
    .num_regs (4)
  ) i_cpu8_core (
    .clk       (clk),
    .rst       (rst),
    .booted    (booted),
    .boot_we   (boot_we),
    .boot_addr (boot_addr),
    .boot_data (boot_data),
    .in_port   (in_port),
    .out_port  (out_port),
    .opcode    (opcode)
  );

  always #(clk_period / 2) clk = ~clk;

  // Control word assembled from its fields
  function automatic logic [31:0] uword(in_plane_e dst, out_plane_e src, logic [3:0] alu,
                                        reg_sel_e sel, logic [1:0] rsrc, logic rs);
    logic [31:0] w;
    w = '0;
    w[reg_src_msb:reg_src_lsb]     = rsrc;
    w[reg_sel_msb:reg_sel_lsb]     = sel;
    w[alu_plane_msb:alu_plane_lsb] = alu;
    w[out_plane_msb:out_plane_lsb] = src;
    w[in_plane_msb:in_plane_lsb]   = dst;
    w[restart_bit]                 = rs;
    return w;
  endfunction

  // Reference MLU where sub is a minus b minus carry
  function automatic logic [7:0] mlu_model(int k, logic c, logic [7:0] x, logic [7:0] y);
    case (k)
      0:       return x & y;
      1:       return x | y;
      2:       return x ^ y;
      3:       return x + y + c;
      4:       return x - y - c;
      5:       return ~x;
      6:       return x;
      default: return x + 8'd1;
    endcase
  endfunction

  function automatic logic [7:0] shift_model(int s, logic [7:0] x);
    case (s)
      0:       return {x[6:0], 1'b0};
      1:       return {1'b0, x[7:1]};
      default: return {x[7], x[7:1]};
    endcase
  endfunction

  task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      $display("=== FAIL ===");
      $fatal(1, "value check failed");
    end
  endtask

  // Four byte lanes per word with lane 3 on top
  task automatic load_word(input int op, input int step, input logic [31:0] w);
    for (int lane = 0; lane < 4; lane++) begin
      @(posedge clk);
      boot_we   <= 1'b1;
      boot_addr <= 13'((op * 32 + step) * 4 + lane);
      boot_data <= w[lane*8 +: 8];
    end
  endtask

  task automatic load_microcode();
    // Return to the dispatcher with bus zero
    done_w = uword(in_opcode, out_none, 4'd0, sel_op_reg0, 2'd0, 1'b1);
    load_word(0, 0, uword(in_opcode, out_in_port, 4'd0, sel_op_reg0, 2'd0, 1'b1));
    // Opcodes 16 to 19 load register r and echo it
    for (int r = 0; r < 4; r++) begin
      load_word(16 + r, 0, uword(in_reg, out_in_port, 4'd0, sel_ctrl, 2'(r), 1'b0));
      load_word(16 + r, 1, uword(in_out_port, out_reg, 4'd0, sel_ctrl, 2'(r), 1'b0));
      load_word(16 + r, 2, done_w);
    end
    // Opcodes 32 to 47 move reg fields into tmp0 and tmp1
    for (int op = 32; op < 48; op++) begin
      load_word(op, 0, uword(in_tmp0, out_reg, 4'd0, sel_op_reg0, 2'd0, 1'b0));
      load_word(op, 1, uword(in_tmp1, out_reg, 4'd0, sel_op_reg1, 2'd0, 1'b0));
      load_word(op, 2, uword(in_out_port, out_tmp1, 4'd0, sel_op_reg0, 2'd0, 1'b0));
      load_word(op, 3, done_w);
    end
    // Opcodes 48 to 55 clear the carry while 56 adds and 57 subtracts with carry set
    for (int k = 0; k < 10; k++) begin
      load_word(48 + k, 0, uword(in_out_port, out_mlu,
                (k < 8) ? {1'b0, 3'(k)} : {1'b1, 3'(k - 5)}, sel_op_reg0, 2'd0, 1'b0));
      load_word(48 + k, 1, done_w);
    end
    for (int s = 0; s < 3; s++) begin
      load_word(58 + s, 0, uword(in_out_port, out_shifter, {2'b00, 2'(s)},
                sel_op_reg0, 2'd0, 1'b0));
      load_word(58 + s, 1, done_w);
    end
    // Step 2 is dead code behind the restart
    load_word(61, 0, uword(in_out_port, out_mlu, {1'b0, mlu_inc_a}, sel_op_reg0, 2'd0, 1'b0));
    load_word(61, 1, done_w);
    load_word(61, 2, uword(in_out_port, out_reg, 4'd0, sel_ctrl, 2'd3, 1'b0));
    @(posedge clk);
    boot_we <= 1'b0;
  endtask

  // Dispatch one program and check out_port after its last step
  task automatic run_op(input string name, input int op, input logic [7:0] data,
                        input int len, input logic [7:0] exp);
    @(posedge clk);
    in_port <= 8'(op);
    @(posedge clk);
    in_port <= data;
    @(negedge clk);
    expect_value({name, " opcode"}, 8'(op), {2'b00, opcode});
    for (int i = 1; i < len; i++) begin
      @(posedge clk);
      in_port <= '0;
    end
    @(negedge clk);
    expect_value(name, exp, out_port);
  endtask

  task automatic load_reg(input int r, input logic [7:0] v);
    run_op("register load", 16 + r, v, 3, v);
  endtask

  // Bound assertions stop the run at their first failure
  always @(negedge clk) begin
    if (i_cpu8_core.i_control_logic.i_cpu8_assertions.fail_count != 0) begin
      $display("concurrent assertion in control logic failed");
      $display("=== FAIL ===");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    #(timeout_cycles * clk_period);
    $display("watchdog timeout after %0d cycles", timeout_cycles);
    $display("=== FAIL ===");
    $fatal(1, "timeout");
  end

  initial begin
    void'($urandom(32'h4af9_8cea));
    clk       = 1'b0;
    rst       = 1'b1;
    booted    = 1'b0;
    boot_we   = 1'b0;
    boot_addr = '0;
    boot_data = '0;
    in_port   = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    load_microcode();
    @(posedge clk);
    booted <= 1'b1;
    repeat (3) @(negedge clk);
    expect_value("boot out_port", 8'h00, out_port);
    expect_value("boot opcode", 8'h00, {2'b00, opcode});

    // Write through sel_ctrl and read back through both opcode fields
    for (int r = 0; r < 4; r++) begin
      a = 8'($urandom);
      load_reg(r, a);
      run_op("read op_reg1", 32 + 5 * r, 8'h00, 4, a);
      run_op("read op_reg0", 54, 8'h00, 2, a);
    end

    for (int n = 0; n < n_rounds; n++) begin
      a = 8'($urandom);
      b = 8'($urandom);
      load_reg(1, a);
      load_reg(2, b);
      run_op("tmp move", 41, 8'h00, 4, b);
      for (int k = 0; k < 10; k++) begin
        run_op("mlu", 48 + k, 8'h00, 2, mlu_model((k < 8) ? k : k - 5, k >= 8, a, b));
      end
    end

    // Even rounds carry a set sign bit
    for (int n = 0; n < n_rounds; n++) begin
      a = 8'($urandom);
      a[7] = (n % 2 == 0) ? 1'b1 : a[7];
      load_reg(1, a);
      run_op("tmp move", 37, 8'h00, 4, a);
      for (int s = 0; s < 3; s++) begin
        run_op("shift", 58 + s, 8'h00, 2, shift_model(s, a));
      end
    end

    // Marker in reg 3 must never reach out_port
    a = 8'($urandom) & 8'h7f;
    load_reg(3, a + 8'h80);
    load_reg(1, a);
    run_op("tmp move", 37, 8'h00, 4, a);
    run_op("restart", 61, 8'h00, 2, a + 8'd1);
    repeat (4) @(negedge clk);
    expect_value("restart marker", a + 8'd1, out_port);

    // Reset lands in the middle of a move
    @(posedge clk);
    in_port <= 8'd41;
    @(posedge clk);
    in_port <= '0;
    @(posedge clk);
    rst <= 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    expect_value("reset out_port", 8'h00, out_port);
    expect_value("reset opcode", 8'h00, {2'b00, opcode});
    @(posedge clk);
    rst <= 1'b0;
    load_reg(2, 8'($urandom));
    run_op("reset clears reg 1", 37, 8'h00, 4, 8'h00);

    if (i_cpu8_core.i_control_logic.i_cpu8_assertions.fail_count != 0) begin
      $display("concurrent assertions failed during the run");
      $display("=== FAIL ===");
      $fatal(1, "assertion failure");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule

/* cpu8.f */
hdl/cpu8_pkg.sv
hdl/microcode_store.sv
hdl/control_logic.sv
hdl/execute_unit.sv
hdl/register_planes.sv
hdl/cpu8_core.sv
sim/cpu8_assertions.sv
sim/cpu8_tb.sv
